/* common/cpu16_pkg.sv */
`default_nettype none

package cpu16_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes and register map
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_W   = 16;
	localparam int INSTR_W  = 16;
	localparam int RADDR_W  = 4;
	localparam int NUM_REGS = 10;                      // r0..r7, SP, T

	localparam logic [RADDR_W-1:0] REG_SP = 4'd8;      // Stack pointer
	localparam logic [RADDR_W-1:0] REG_T  = 4'd9;      // Compare result

	////////////////////////////////////////////////////////////////////////////
	// Operation and operand-source encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		EXE_ADD  = 4'h0,
		EXE_SUB  = 4'h1,
		EXE_AND  = 4'h2,
		EXE_OR   = 4'h3,
		EXE_SLL  = 4'h4,
		EXE_SRL  = 4'h5,
		EXE_SRA  = 4'h6,
		EXE_SRAV = 4'h7,
		EXE_CMP  = 4'h8,                               // 0 if equal, else 1
		EXE_PASS = 4'h9,                               // Result is op1
		EXE_NOP  = 4'hA
	} exe_op_e;

	typedef enum logic [2:0] {
		SEL_REG1 = 3'd0,
		SEL_REG2 = 3'd1,
		SEL_PC   = 3'd2,
		SEL_IMM  = 3'd3,
		SEL_ZERO = 3'd4
	} opsel_e;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic               valid;
		exe_op_e            op;
		logic [RADDR_W-1:0] dest;
		logic               reg_write;
		logic               mem_read;
		logic               mem_write;
		opsel_e             op1_sel;
		opsel_e             op2_sel;
		logic [DATA_W-1:0]  imm;                       // Already extended
	} dec_ctrl_t;

	typedef struct packed {
		logic               valid;
		exe_op_e            op;
		logic [RADDR_W-1:0] dest;
		logic               reg_write;
		logic               mem_read;
		logic               mem_write;
		logic [DATA_W-1:0]  op1;
		logic [DATA_W-1:0]  op2;
		logic [DATA_W-1:0]  store_val;                 // SW data, taken from ry
	} exe_in_t;

	typedef struct packed {
		logic               valid;
		logic [DATA_W-1:0]  value;                     // ALU result or address
		logic [RADDR_W-1:0] dest;
		logic               reg_write;
		logic               mem_read;
		logic               mem_write;
		logic [DATA_W-1:0]  store_val;
	} exe_result_t;

	typedef struct packed {
		logic               en;
		logic [RADDR_W-1:0] addr;
		logic [DATA_W-1:0]  data;
	} wb_t;

endpackage

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire logic [cpu16_pkg::INSTR_W-1:0] instr,
	input  wire logic                          instr_valid,
	output cpu16_pkg::dec_ctrl_t               ctrl,
	output logic [cpu16_pkg::RADDR_W-1:0]      rs1,
	output logic [cpu16_pkg::RADDR_W-1:0]      rs2
);
	import cpu16_pkg::*;

	logic [RADDR_W-1:0] rx;
	logic [RADDR_W-1:0] ry;
	logic [RADDR_W-1:0] rz;
	logic [DATA_W-1:0]  shamt;

	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};
	assign shamt = (instr[4:2] == 3'b000) ? DATA_W'(8) : DATA_W'(instr[4:2]); // 0 means 8

	always_comb begin
		ctrl         = '0;
		ctrl.valid   = instr_valid;
		ctrl.op      = EXE_NOP;                        // Branches and unknown words
		ctrl.op1_sel = SEL_ZERO;
		ctrl.op2_sel = SEL_ZERO;
		rs1          = '0;
		rs2          = '0;

		case (instr[15:11])
			5'b01001: begin                            // ADDIU rx, imm8
				ctrl.op = EXE_ADD; rs1 = rx; ctrl.dest = rx; ctrl.reg_write = 1'b1;
				ctrl.op1_sel = SEL_REG1; ctrl.op2_sel = SEL_IMM;
				ctrl.imm = {{8{instr[7]}}, instr[7:0]};
			end
			5'b01000: begin                            // ADDIU3 rx, ry, imm4
				ctrl.op = EXE_ADD; rs1 = rx; ctrl.dest = ry; ctrl.reg_write = 1'b1;
				ctrl.op1_sel = SEL_REG1; ctrl.op2_sel = SEL_IMM;
				ctrl.imm = {{12{instr[3]}}, instr[3:0]};
			end
			5'b01100: begin
				if (instr[10:8] == 3'b011) begin       // ADDSP imm8
					ctrl.op = EXE_ADD; rs1 = REG_SP; ctrl.dest = REG_SP; ctrl.reg_write = 1'b1;
					ctrl.op1_sel = SEL_REG1; ctrl.op2_sel = SEL_IMM;
					ctrl.imm = {{8{instr[7]}}, instr[7:0]};
				end
			end
			5'b11100: begin                            // ADDU / SUBU, rz = rx op ry
				if (instr[0]) begin
					ctrl.op = instr[1] ? EXE_SUB : EXE_ADD;
					rs1 = rx; rs2 = ry; ctrl.dest = rz; ctrl.reg_write = 1'b1;
					ctrl.op1_sel = SEL_REG1; ctrl.op2_sel = SEL_REG2;
				end
			end
			5'b11101: begin
				rs1 = rx;
				rs2 = ry;
				ctrl.op1_sel = SEL_REG1;
				ctrl.op2_sel = SEL_REG2;
				case (instr[4:0])
					5'b01100: begin ctrl.op = EXE_AND; ctrl.dest = rx; ctrl.reg_write = 1'b1; end
					5'b01101: begin ctrl.op = EXE_OR;  ctrl.dest = rx; ctrl.reg_write = 1'b1; end
					5'b01010: begin ctrl.op = EXE_CMP; ctrl.dest = REG_T; ctrl.reg_write = 1'b1; end
					5'b00111: begin                    // SRAV: ry = ry >>> rx
						ctrl.op = EXE_SRAV; ctrl.dest = ry; ctrl.reg_write = 1'b1;
						ctrl.op1_sel = SEL_REG2; ctrl.op2_sel = SEL_REG1;
					end
					5'b00000: begin
						if (instr[7:5] == 3'b010) begin // MFPC rx
							ctrl.op = EXE_PASS; ctrl.dest = rx; ctrl.reg_write = 1'b1;
							ctrl.op1_sel = SEL_PC;
						end
					end
					default: ;                         // JR, JALR, JRRA fall to NOP
				endcase
			end
			5'b01101: begin                            // LI rx, imm8
				ctrl.op = EXE_PASS; ctrl.dest = rx; ctrl.reg_write = 1'b1;
				ctrl.op1_sel = SEL_IMM;
				ctrl.imm = {8'h00, instr[7:0]};
			end
			5'b01111: begin
				if (instr[4:0] == 5'b00000) begin      // MOVE rx, ry
					ctrl.op = EXE_PASS; rs2 = ry; ctrl.dest = rx; ctrl.reg_write = 1'b1;
					ctrl.op1_sel = SEL_REG2;
				end
			end
			5'b00110: begin                            // SLL / SRL / SRA, rx = ry sh imm3
				if (instr[1:0] != 2'b01) begin
					ctrl.op = (instr[1:0] == 2'b00) ? EXE_SLL :
					          (instr[1:0] == 2'b10) ? EXE_SRL : EXE_SRA;
					rs2 = ry; ctrl.dest = rx; ctrl.reg_write = 1'b1;
					ctrl.op1_sel = SEL_REG2; ctrl.op2_sel = SEL_IMM;
					ctrl.imm = shamt;
				end
			end
			5'b10011, 5'b11011: begin                  // LW / SW, address rx + imm5
				ctrl.op = EXE_ADD; rs1 = rx; rs2 = ry; ctrl.dest = ry;
				ctrl.mem_read  = ~instr[14];
				ctrl.mem_write = instr[14];
				ctrl.reg_write = ~instr[14];           // LW writes in the memory stage
				ctrl.op1_sel = SEL_REG1; ctrl.op2_sel = SEL_IMM;
				ctrl.imm = {{11{instr[4]}}, instr[4:0]};
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic                         clk,
	input  wire logic                         arst_n,
	input  wire logic [cpu16_pkg::RADDR_W-1:0] rs1,
	input  wire logic [cpu16_pkg::RADDR_W-1:0] rs2,
	output logic [cpu16_pkg::DATA_W-1:0]      rd1,
	output logic [cpu16_pkg::DATA_W-1:0]      rd2,
	input  wire cpu16_pkg::wb_t               wb
);
	import cpu16_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && (wb.addr < NUM_REGS)) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// No bypass, a same-cycle write is seen one cycle later
	assign rd1 = (rs1 < NUM_REGS) ? regs[rs1] : '0;
	assign rd2 = (rs2 < NUM_REGS) ? regs[rs2] : '0;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Decoder and ALU together must only ever target real registers
	a_wb_addr_range : assert property (
		@(posedge clk) disable iff (!arst_n)
		wb.en |-> (wb.addr < NUM_REGS)
	) else $error("reg_file: write to register %0d", wb.addr);

endmodule

`default_nettype wire

/* logic/id_exe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_exe_reg (
	input  wire logic                        clk,
	input  wire logic                        arst_n,
	input  wire cpu16_pkg::dec_ctrl_t        ctrl,
	input  wire logic [cpu16_pkg::DATA_W-1:0] rd1,
	input  wire logic [cpu16_pkg::DATA_W-1:0] rd2,
	input  wire logic [cpu16_pkg::DATA_W-1:0] pc,
	input  wire logic                        hold,
	input  wire logic                        flush,
	output cpu16_pkg::exe_in_t               exe_in,
	output logic [31:0]                      issue_count
);
	import cpu16_pkg::*;

	logic    valid_q;
	logic    capture;
	exe_in_t payload_d;
	exe_in_t payload_q;

	function automatic logic [DATA_W-1:0] pick_operand(
		input opsel_e            sel,
		input logic [DATA_W-1:0] r1,
		input logic [DATA_W-1:0] r2,
		input logic [DATA_W-1:0] p,
		input logic [DATA_W-1:0] imm
	);
		case (sel)
			SEL_REG1: return r1;
			SEL_REG2: return r2;
			SEL_PC:   return p;
			SEL_IMM:  return imm;
			default:  return '0;
		endcase
	endfunction

	assign capture = ~flush & ~hold;                   // Flush wins over hold

	always_comb begin
		payload_d.valid     = ctrl.valid;
		payload_d.op        = ctrl.op;
		payload_d.dest      = ctrl.dest;
		payload_d.reg_write = ctrl.reg_write;
		payload_d.mem_read  = ctrl.mem_read;
		payload_d.mem_write = ctrl.mem_write;
		payload_d.op1       = pick_operand(ctrl.op1_sel, rd1, rd2, pc, ctrl.imm);
		payload_d.op2       = pick_operand(ctrl.op2_sel, rd1, rd2, pc, ctrl.imm);
		payload_d.store_val = rd2;                     // SW data is ry
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q     <= 1'b0;
			issue_count <= '0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (!hold) begin
			valid_q <= ctrl.valid;
			if (ctrl.valid) begin
				issue_count <= issue_count + 32'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			payload_q <= payload_d;
		end
	end

	// Held entry stays invisible downstream until hold drops
	always_comb begin
		exe_in       = payload_q;
		exe_in.valid = valid_q & ~hold;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_flush_clears : assert property (
		@(posedge clk) disable iff (!arst_n)
		flush |=> !valid_q
	) else $error("id_exe_reg: valid survived a flush");

	a_hold_stable : assert property (
		@(posedge clk) disable iff (!arst_n)
		(hold && !flush && valid_q) |=> ($stable(payload_q) && $stable(issue_count))
	) else $error("id_exe_reg: payload changed during hold");

endmodule

`default_nettype wire

/* execute/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire cpu16_pkg::exe_in_t   exe_in,
	output cpu16_pkg::exe_result_t    result,
	output cpu16_pkg::wb_t            wb
);
	import cpu16_pkg::*;

	logic [DATA_W-1:0] alu_val;
	logic [3:0]        shamt;
	logic              res_valid_q;
	exe_result_t       res_d;
	exe_result_t       res_q;

	assign shamt = exe_in.op2[3:0];                    // Shifts never exceed 15

	always_comb begin
		case (exe_in.op)
			EXE_ADD:            alu_val = exe_in.op1 + exe_in.op2;
			EXE_SUB:            alu_val = exe_in.op1 - exe_in.op2;
			EXE_AND:            alu_val = exe_in.op1 & exe_in.op2;
			EXE_OR:             alu_val = exe_in.op1 | exe_in.op2;
			EXE_SLL:            alu_val = exe_in.op1 << shamt;
			EXE_SRL:            alu_val = exe_in.op1 >> shamt;
			EXE_SRA, EXE_SRAV:  alu_val = DATA_W'($signed(exe_in.op1) >>> shamt);
			EXE_CMP:            alu_val = (exe_in.op1 == exe_in.op2) ? '0 : DATA_W'(1);
			EXE_PASS:           alu_val = exe_in.op1;
			default:            alu_val = '0;          // NOP
		endcase
	end

	always_comb begin
		res_d.valid     = exe_in.valid;
		res_d.value     = alu_val;
		res_d.dest      = exe_in.dest;
		res_d.reg_write = exe_in.reg_write;
		res_d.mem_read  = exe_in.mem_read;
		res_d.mem_write = exe_in.mem_write;
		res_d.store_val = exe_in.store_val;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid_q <= 1'b0;
		end else begin
			res_valid_q <= exe_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_in.valid) begin
			res_q <= res_d;
		end
	end

	always_comb begin
		result       = res_q;
		result.valid = res_valid_q;
	end

	// LW data only exists after the memory stage
	assign wb.en   = res_valid_q & res_q.reg_write & ~res_q.mem_read;
	assign wb.addr = res_q.dest;
	assign wb.data = res_q.value;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_mem_flags_exclusive : assert property (
		@(posedge clk) disable iff (!arst_n)
		result.valid |-> !(result.mem_read && result.mem_write)
	) else $error("alu_exec: load and store flagged together");

endmodule

`default_nettype wire

/* logic/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic [cpu16_pkg::INSTR_W-1:0] instr,
	input  wire logic                          instr_valid,
	input  wire logic [cpu16_pkg::DATA_W-1:0]  pc,
	input  wire logic                          hold,
	input  wire logic                          flush,
	output cpu16_pkg::exe_result_t             result,
	output logic [31:0]                        issue_count
);
	import cpu16_pkg::*;

	dec_ctrl_t          dec_ctrl;
	logic [RADDR_W-1:0] rs1;
	logic [RADDR_W-1:0] rs2;
	logic [DATA_W-1:0]  rd1;
	logic [DATA_W-1:0]  rd2;
	exe_in_t            exe_in;
	wb_t                wb;

	instr_decoder u_instr_decoder (
		.instr       (instr),
		.instr_valid (instr_valid),
		.ctrl        (dec_ctrl),
		.rs1         (rs1),
		.rs2         (rs2)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd1    (rd1),
		.rd2    (rd2),
		.wb     (wb)                                   // Write-back from execute
	);

	id_exe_reg u_id_exe_reg (
		.clk         (clk),
		.arst_n      (arst_n),
		.ctrl        (dec_ctrl),
		.rd1         (rd1),
		.rd2         (rd2),
		.pc          (pc),
		.hold        (hold),
		.flush       (flush),
		.exe_in      (exe_in),
		.issue_count (issue_count)
	);

	alu_exec u_alu_exec (
		.clk    (clk),
		.arst_n (arst_n),
		.exe_in (exe_in),
		.result (result),
		.wb     (wb)
	);

endmodule

`default_nettype wire

/* test/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
	import cpu16_pkg::*;

	localparam int          CLK_PERIOD  = 40;
	localparam int          N_ENTRIES   = 27;
	localparam int          RESULT_WAIT = 3;          // Edges allowed from issue to result
	localparam int          LATENCY     = 2;          // Edges from capture to result
	localparam logic [15:0] DECOY_INSTR = 16'h68A5;   // LI r0, 0xA5 offered during hold
	localparam exe_result_t NO_RESULT   = '0;

	typedef enum logic [4:0] {
		K_LI, K_MOVE, K_ADDIU, K_ADDIU3, K_ADDSP, K_ADDU, K_SUBU, K_AND, K_OR,
		K_CMP, K_SRAV, K_MFPC, K_SLL, K_SRL, K_SRA, K_LW, K_SW
	} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [2:0]  rx;
		logic [2:0]  ry;
		logic [2:0]  rz;
		logic [7:0]  imm;
		logic [15:0] pc;
		logic [3:0]  hold;                             // Hold edges after capture
		logic        flush;
		logic        rnd;                              // imm drawn from $urandom
	} entry_t;

	logic                clk;
	logic                arst_n;
	logic [INSTR_W-1:0]  instr;
	logic                instr_valid;
	logic [DATA_W-1:0]   pc;
	logic                hold;
	logic                flush;
	exe_result_t         result;
	logic [31:0]         issue_count;

	entry_t              stim [N_ENTRIES];
	logic [DATA_W-1:0]   model [NUM_REGS];             // Reference register contents
	int                  issued;
	int                  errors;

	exec_core u_exec_core (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.pc          (pc),
		.hold        (hold),
		.flush       (flush),
		.result      (result),
		.issue_count (issue_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic entry_t make_entry(input kind_e k, input int rx, input int ry,
			input int rz, input logic [7:0] imm, input int hold_n, input bit fl, input bit rnd);
		entry_t e;
		e = '0;
		e.kind  = k;
		e.rx    = 3'(rx);
		e.ry    = 3'(ry);
		e.rz    = 3'(rz);
		e.imm   = imm;
		e.hold  = 4'(hold_n);
		e.flush = fl;
		e.rnd   = rnd;
		return e;
	endfunction

	task automatic load_stimulus();
		stim[0]  = make_entry(K_LI,     1, 0, 0, 8'h00, 0, 0, 1);
		stim[1]  = make_entry(K_LI,     2, 0, 0, 8'h00, 0, 0, 1);
		stim[2]  = make_entry(K_LI,     3, 0, 0, 8'h05, 0, 0, 0);  // SRAV amount
		stim[3]  = make_entry(K_MOVE,   4, 1, 0, 8'h00, 0, 0, 0);
		stim[4]  = make_entry(K_ADDIU,  1, 0, 0, 8'hF3, 0, 0, 0);
		stim[5]  = make_entry(K_ADDIU3, 2, 5, 0, 8'h0A, 0, 0, 0);
		stim[6]  = make_entry(K_ADDSP,  0, 0, 0, 8'h40, 0, 0, 0);
		stim[7]  = make_entry(K_ADDSP,  0, 0, 0, 8'hFE, 0, 0, 0);
		stim[8]  = make_entry(K_ADDU,   1, 2, 6, 8'h00, 0, 0, 0);
		stim[9]  = make_entry(K_SUBU,   1, 2, 7, 8'h00, 0, 0, 0);
		stim[10] = make_entry(K_AND,    4, 2, 0, 8'h00, 0, 0, 0);
		stim[11] = make_entry(K_OR,     5, 3, 0, 8'h00, 0, 0, 0);
		stim[12] = make_entry(K_CMP,    1, 1, 0, 8'h00, 0, 0, 0);
		stim[13] = make_entry(K_CMP,    1, 2, 0, 8'h00, 0, 0, 0);
		stim[14] = make_entry(K_SLL,    6, 1, 0, 8'h00, 0, 0, 0);  // imm3 of 0 shifts by 8
		stim[15] = make_entry(K_SRL,    7, 2, 0, 8'h03, 0, 0, 0);
		stim[16] = make_entry(K_SRA,    0, 1, 0, 8'h05, 0, 0, 0);
		stim[17] = make_entry(K_SRAV,   3, 2, 0, 8'h00, 0, 0, 0);
		stim[18] = make_entry(K_MFPC,   2, 0, 0, 8'h00, 0, 0, 0);
		stim[19] = make_entry(K_LW,     1, 6, 0, 8'h1C, 0, 0, 0);
		stim[20] = make_entry(K_SW,     5, 7, 0, 8'h07, 0, 0, 0);
		stim[21] = make_entry(K_LI,     1, 0, 0, 8'h00, 3, 0, 1);
		stim[22] = make_entry(K_ADDU,   1, 2, 4, 8'h00, 0, 1, 0);  // Flushed at capture
		stim[23] = make_entry(K_MOVE,   3, 1, 0, 8'h00, 2, 1, 0);  // Flushed while held
		stim[24] = make_entry(K_MOVE,   5, 4, 0, 8'h00, 0, 0, 0);
		stim[25] = make_entry(K_ADDU,   1, 3, 0, 8'h00, 0, 0, 0);
		stim[26] = make_entry(K_MOVE,   0, 6, 0, 8'h00, 0, 0, 0);  // r6 untouched by LW
		for (int i = 0; i < N_ENTRIES; i++) begin
			stim[i].pc = 16'h0400 + 16'(i * 2);
			if (stim[i].rnd) begin
				stim[i].imm = 8'($urandom);
			end
		end
	endtask

	function automatic logic [15:0] encode_instr(input entry_t e);
		case (e.kind)
			K_LI:     return {5'b01101, e.rx, e.imm};
			K_MOVE:   return {5'b01111, e.rx, e.ry, 5'b00000};
			K_ADDIU:  return {5'b01001, e.rx, e.imm};
			K_ADDIU3: return {5'b01000, e.rx, e.ry, 1'b0, e.imm[3:0]};
			K_ADDSP:  return {5'b01100, 3'b011, e.imm};
			K_ADDU:   return {5'b11100, e.rx, e.ry, e.rz, 2'b01};
			K_SUBU:   return {5'b11100, e.rx, e.ry, e.rz, 2'b11};
			K_AND:    return {5'b11101, e.rx, e.ry, 5'b01100};
			K_OR:     return {5'b11101, e.rx, e.ry, 5'b01101};
			K_CMP:    return {5'b11101, e.rx, e.ry, 5'b01010};
			K_SRAV:   return {5'b11101, e.rx, e.ry, 5'b00111};
			K_MFPC:   return {5'b11101, e.rx, 3'b010, 5'b00000};
			K_SLL:    return {5'b00110, e.rx, e.ry, e.imm[2:0], 2'b00};
			K_SRL:    return {5'b00110, e.rx, e.ry, e.imm[2:0], 2'b10};
			K_SRA:    return {5'b00110, e.rx, e.ry, e.imm[2:0], 2'b11};
			K_LW:     return {5'b10011, e.rx, e.ry, e.imm[4:0]};
			default:  return {5'b11011, e.rx, e.ry, e.imm[4:0]};  // SW
		endcase
	endfunction

	// Result the ISA defines for an entry under the current model
	function automatic exe_result_t predict(input entry_t e);
		exe_result_t r;
		logic [3:0]  sh;
		sh          = (e.imm[2:0] == 3'd0) ? 4'd8 : {1'b0, e.imm[2:0]};
		r           = '0;
		r.valid     = !e.flush;
		r.reg_write = 1'b1;
		r.dest      = {1'b0, e.rx};
		case (e.kind)
			K_LI:     r.value = {8'h00, e.imm};
			K_MOVE:   r.value = model[e.ry];
			K_ADDIU:  r.value = model[e.rx] + {{8{e.imm[7]}}, e.imm};
			K_ADDIU3: begin
				r.dest  = {1'b0, e.ry};
				r.value = model[e.rx] + {{12{e.imm[3]}}, e.imm[3:0]};
			end
			K_ADDSP: begin
				r.dest  = REG_SP;
				r.value = model[REG_SP] + {{8{e.imm[7]}}, e.imm};
			end
			K_ADDU: begin
				r.dest  = {1'b0, e.rz};
				r.value = model[e.rx] + model[e.ry];
			end
			K_SUBU: begin
				r.dest  = {1'b0, e.rz};
				r.value = model[e.rx] - model[e.ry];
			end
			K_AND:    r.value = model[e.rx] & model[e.ry];
			K_OR:     r.value = model[e.rx] | model[e.ry];
			K_CMP: begin
				r.dest  = REG_T;
				r.value = (model[e.rx] == model[e.ry]) ? 16'd0 : 16'd1;
			end
			K_SRAV: begin
				r.dest  = {1'b0, e.ry};
				r.value = $signed(model[e.ry]) >>> model[e.rx][3:0];
			end
			K_MFPC:   r.value = e.pc;
			K_SLL:    r.value = model[e.ry] << sh;
			K_SRL:    r.value = model[e.ry] >> sh;
			K_SRA:    r.value = $signed(model[e.ry]) >>> sh;
			default: begin                             // LW and SW give an address only
				r.dest      = {1'b0, e.ry};
				r.value     = model[e.rx] + {{11{e.imm[4]}}, e.imm[4:0]};
				r.mem_read  = (e.kind == K_LW);
				r.mem_write = (e.kind == K_SW);
				r.reg_write = (e.kind == K_LW);
				r.store_val = model[e.ry];
			end
		endcase
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input exe_result_t got, input exe_result_t exp, input string what);
		logic  bad;
		string got_s;
		string exp_s;
		bad = (got.valid !== exp.valid);
		if (exp.valid) begin
			bad |= (got.value !== exp.value) || (got.reg_write !== exp.reg_write);
			bad |= (got.mem_read !== exp.mem_read) || (got.mem_write !== exp.mem_write);
			if (exp.reg_write) bad |= (got.dest !== exp.dest);
			if (exp.mem_write) bad |= (got.store_val !== exp.store_val);
		end
		if (bad) begin
			got_s = $sformatf("v=%b val=%h dst=%0d rw=%b mr=%b mw=%b st=%h", got.valid,
				got.value, got.dest, got.reg_write, got.mem_read, got.mem_write, got.store_val);
			exp_s = $sformatf("v=%b val=%h dst=%0d rw=%b mr=%b mw=%b st=%h", exp.valid,
				exp.value, exp.dest, exp.reg_write, exp.mem_read, exp.mem_write, exp.store_val);
			report_failure($sformatf("FAIL at %0t: %s got %s, expected %s", $time, what,
				got_s, exp_s));
		end
	endtask

	task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("FAIL at %0t: %s issue_count %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_idle();
		instr       = '0;
		instr_valid = 1'b0;
		hold        = 1'b0;
		flush       = 1'b0;
	endtask

	task automatic run_entry(input int idx);
		entry_t      e;
		exe_result_t exp;
		exe_result_t got;
		logic        seen;
		int          waited;
		string       tag;
		e   = stim[idx];
		exp = predict(e);
		tag = $sformatf("entry %0d (%s)", idx, e.kind.name());
		got = NO_RESULT;
		@(negedge clk);
		instr       = encode_instr(e);
		instr_valid = 1'b1;
		pc          = e.pc;
		hold        = 1'b0;
		flush       = e.flush && (e.hold == 0);
		if (!(e.flush && (e.hold == 0))) issued++;
		for (int i = 0; i < int'(e.hold); i++) begin
			@(negedge clk);
			check_result(result, NO_RESULT, {tag, " while held"});
			instr       = DECOY_INSTR;                 // Must be dropped
			instr_valid = 1'b1;
			hold        = 1'b1;
			flush       = e.flush && (i == int'(e.hold) - 1);  // Flush beats hold
		end
		if (exp.valid) begin
			seen   = 1'b0;
			waited = 0;
			while (!seen && waited < RESULT_WAIT) begin
				@(negedge clk);
				waited++;
				seen = result.valid;
				got  = result;
				drive_idle();
			end
			if (!seen) begin
				report_failure($sformatf("No result for %s within %0d cycles", tag, RESULT_WAIT));
			end
			if (waited != LATENCY) begin
				report_failure($sformatf("FAIL at %0t: %s result after %0d edges, expected %0d",
					$time, tag, waited, LATENCY));
			end
			check_result(got, exp, tag);
			if (exp.reg_write && !exp.mem_read) model[exp.dest] = exp.value;
		end else begin
			repeat (RESULT_WAIT) begin
				@(negedge clk);
				check_result(result, NO_RESULT, {tag, " after flush"});
				drive_idle();
			end
		end
		// NOP gap so the next entry reads the written register
		repeat (2) begin
			@(negedge clk);
			check_result(result, NO_RESULT, {tag, " extra result"});
			drive_idle();
		end
		check_count(issue_count, 32'(issued), tag);
	endtask

	initial begin : main
		arst_n = 1'b0;
		pc     = '0;
		drive_idle();
		issued = 0;
		errors = 0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model[i] = '0;
		end
		void'($urandom(32'h3ce));
		load_stimulus();
		repeat (5) @(negedge clk);
		check_result(result, NO_RESULT, "reset");
		check_count(issue_count, 32'd0, "reset");
		arst_n = 1'b1;
		for (int i = 0; i < N_ENTRIES; i++) begin
			run_entry(i);
		end
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		@(posedge arst_n);
		for (int i = 0; i < N_ENTRIES; i++) begin
			cycles += int'(stim[i].hold) + 8;          // Issue, hold, wait and gap
		end
		#((cycles + 20) * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", cycles + 20);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* sim.f */
common/cpu16_pkg.sv
decode/instr_decoder.sv
logic/reg_file.sv
logic/id_exe_reg.sv
execute/alu_exec.sv
logic/exec_core.sv
test/tb_exec_core.sv

/* run.sh */
#!/bin/sh
# Build and run the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_core -f sim.f || exit 1
out=$(./obj_dir/Vtb_exec_core 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
